//--- div_serial.sv
`timescale 1ns/100ps
`default_nettype none

module div_serial import muldiv_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    muldiv_if.div  ifc
);

    logic        running;
    logic [4:0]  count;
    logic        last;

    word_t       rem_q;       // partial remainder.
    word_t       dvd_q;       // dividend bits shift out, quotient bits shift in.
    word_t       dvs_q;
    word_t       dividend_q;
    logic        neg_quo;
    logic        neg_rem;
    logic        zero_div;

    word_t       mag_a;
    word_t       mag_b;
    logic [32:0] trial;
    logic [32:0] diff;
    logic        take;
    word_t       rem_next;
    word_t       quo_next;

    assign mag_a = (ifc.is_signed && ifc.op_a[31]) ? -ifc.op_a : ifc.op_a;
    assign mag_b = (ifc.is_signed && ifc.op_b[31]) ? -ifc.op_b : ifc.op_b;

    // one restoring step.
    assign trial    = {rem_q, dvd_q[31]};
    assign diff     = trial - {1'b0, dvs_q};
    assign take     = (trial >= {1'b0, dvs_q});
    assign rem_next = take ? diff[31:0] : trial[31:0];
    assign quo_next = {dvd_q[30:0], take};

    assign last = running && (count == 5'd31);

    always_ff @(posedge clk) begin
        if (reset) begin
            running      <= 1'b0;
            count        <= 5'd0;
            ifc.div_done <= 1'b0;
        end else begin
            ifc.div_done <= last;
            if (ifc.div_start) begin
                running <= 1'b1;
                count   <= 5'd0;
            end else if (running) begin
                count <= count + 5'd1;
                if (last)
                    running <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ifc.div_start) begin
            rem_q      <= '0;
            dvd_q      <= mag_a;
            dvs_q      <= mag_b;
            dividend_q <= ifc.op_a;
            neg_quo    <= ifc.is_signed && (ifc.op_a[31] ^ ifc.op_b[31]);
            neg_rem    <= ifc.is_signed && ifc.op_a[31]; // remainder follows the dividend.
            zero_div   <= (ifc.op_b == '0);
        end else if (running) begin
            rem_q <= rem_next;
            dvd_q <= quo_next;
        end
    end

    // results are fixed up on the final step, together with div_done.
    always_ff @(posedge clk) begin
        if (last) begin
            if (zero_div) begin
                ifc.quotient  <= '1;
                ifc.remainder <= dividend_q;
            end else begin
                ifc.quotient  <= neg_quo ? -quo_next : quo_next;
                ifc.remainder <= neg_rem ? -rem_next : rem_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- hilo_regs.sv
`timescale 1ns/100ps
`default_nettype none

module hilo_regs import muldiv_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    wr_hi,
    input  logic    wr_lo,
    input  wr_src_t wr_src,
    input  word_t   wr_data_rs,
    muldiv_if.regs  ifc,
    output word_t   hi,
    output word_t   lo
);

    word_t hi_next;
    word_t lo_next;

    always_comb begin
        unique case (wr_src)
            WR_SRC_PROD: begin
                hi_next = ifc.product[63:32];
                lo_next = ifc.product[31:0];
            end
            WR_SRC_DIV: begin
                hi_next = ifc.remainder;
                lo_next = ifc.quotient;
            end
            default: begin
                hi_next = wr_data_rs; // a move enables only one of the two.
                lo_next = wr_data_rs;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else begin
            if (wr_hi)
                hi <= hi_next;
            if (wr_lo)
                lo <= lo_next;
        end
    end

endmodule

`default_nettype wire

//--- mul_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module mul_pipe import muldiv_pkg::*; #(
    parameter int MUL_LATENCY = 2
) (
    input  logic   clk,
    input  logic   reset,
    muldiv_if.mul  ifc
);

    logic signed [32:0] ext_a;
    logic signed [32:0] ext_b;
    logic signed [65:0] full;

    dword_t                 prod_q [MUL_LATENCY];
    logic [MUL_LATENCY-1:0] vld_q;

    // one extra bit lets a single signed multiply cover both forms.
    assign ext_a = {ifc.is_signed & ifc.op_a[31], ifc.op_a};
    assign ext_b = {ifc.is_signed & ifc.op_b[31], ifc.op_b};
    assign full  = ext_a * ext_b;

    always_ff @(posedge clk) begin
        if (ifc.mul_start)
            prod_q[0] <= full[63:0];
        for (int i = 1; i < MUL_LATENCY; i++) begin
            prod_q[i] <= prod_q[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= ifc.mul_start;
            for (int i = 1; i < MUL_LATENCY; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    assign ifc.product  = prod_q[MUL_LATENCY-1];
    assign ifc.mul_done = vld_q[MUL_LATENCY-1]; // valid leaving the last stage.

endmodule

`default_nettype wire

//--- muldiv_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_ctrl import muldiv_pkg::*; #(
    parameter int MUL_LATENCY = 2
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    issue,
    input  opcode_t opcode,
    input  func_t   func,
    input  word_t   rs_val,
    input  word_t   rt_val,
    output logic    busy,
    muldiv_if.ctrl  ifc,
    output logic    wr_hi,
    output logic    wr_lo,
    output wr_src_t wr_src,
    output word_t   wr_data_rs
);

    ctrl_state_t state;

    logic accept;
    logic is_mthi;
    logic is_mtlo;
    logic is_mul;
    logic is_div;
    logic mul_fin;
    logic div_fin;

    // the multiplier depth is fixed by the pipeline registers it is built with.
    if (MUL_LATENCY < 1 || MUL_LATENCY > 4) begin : g_latency_range
        $error("muldiv_ctrl: MUL_LATENCY must lie between 1 and 4");
    end

    assign accept  = issue && (state == IDLE) && (opcode == OP_SPECIAL);
    assign is_mthi = accept && (func == FUNC_MTHI);
    assign is_mtlo = accept && (func == FUNC_MTLO);
    assign is_mul  = accept && ((func == FUNC_MULT) || (func == FUNC_MULTU));
    assign is_div  = accept && ((func == FUNC_DIV) || (func == FUNC_DIVU));

    assign mul_fin = (state == MUL_WAIT) && ifc.mul_done;
    assign div_fin = (state == DIV_WAIT) && ifc.div_done;

    assign busy = (state != IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            unique case (state)
                IDLE: begin
                    if (is_mul)
                        state <= MUL_WAIT;
                    else if (is_div)
                        state <= DIV_WAIT;
                end
                MUL_WAIT: if (mul_fin) state <= IDLE;
                DIV_WAIT: if (div_fin) state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // start strobes are one cycle wide since accept needs IDLE.
    always_ff @(posedge clk) begin
        if (reset) begin
            ifc.mul_start <= 1'b0;
            ifc.div_start <= 1'b0;
        end else begin
            ifc.mul_start <= is_mul;
            ifc.div_start <= is_div;
        end
    end

    always_ff @(posedge clk) begin
        if (is_mul || is_div) begin
            ifc.op_a      <= rs_val;
            ifc.op_b      <= rt_val;
            ifc.is_signed <= !func[0]; // the unsigned forms have bit 0 set.
        end
    end

    // moves write straight away, results write when the datapath reports done.
    assign wr_hi      = is_mthi || mul_fin || div_fin;
    assign wr_lo      = is_mtlo || mul_fin || div_fin;
    assign wr_data_rs = rs_val;

    always_comb begin
        unique case (state)
            MUL_WAIT: wr_src = WR_SRC_PROD;
            DIV_WAIT: wr_src = WR_SRC_DIV;
            default:  wr_src = WR_SRC_RS;
        endcase
    end

endmodule

`default_nettype wire

//--- muldiv_if.sv
`timescale 1ns/100ps
`default_nettype none

interface muldiv_if import muldiv_pkg::*; ();

    logic   mul_start;
    logic   div_start;
    logic   is_signed;
    word_t  op_a;
    word_t  op_b;

    logic   mul_done;
    dword_t product;

    logic   div_done;
    word_t  quotient;
    word_t  remainder;

    modport ctrl (
        output mul_start,
        output div_start,
        output is_signed,
        output op_a,
        output op_b,
        input  mul_done,
        input  div_done
    );

    modport mul (
        input  mul_start,
        input  is_signed,
        input  op_a,
        input  op_b,
        output mul_done,
        output product
    );

    modport div (
        input  div_start,
        input  is_signed,
        input  op_a,
        input  op_b,
        output div_done,
        output quotient,
        output remainder
    );

    modport regs (
        input  product,
        input  quotient,
        input  remainder
    );

endinterface

`default_nettype wire

//--- muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

    // data and field widths of the integer core.
    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  func_t;

    // source select for the HI/LO write path.
    typedef logic [1:0]  wr_src_t;

    localparam opcode_t OP_SPECIAL = 6'h00;

    localparam func_t FUNC_MTHI  = 6'h11;
    localparam func_t FUNC_MTLO  = 6'h13;
    localparam func_t FUNC_MULT  = 6'h18;
    localparam func_t FUNC_MULTU = 6'h19;
    localparam func_t FUNC_DIV   = 6'h1a;
    localparam func_t FUNC_DIVU  = 6'h1b;

    localparam wr_src_t WR_SRC_PROD = 2'd0; // product, upper half to HI.
    localparam wr_src_t WR_SRC_DIV  = 2'd1; // remainder to HI, quotient to LO.
    localparam wr_src_t WR_SRC_RS   = 2'd2; // rs operand of a move.

    // the unit is busy in every state but IDLE.
    typedef enum logic [1:0] {
        IDLE,
        MUL_WAIT,
        DIV_WAIT
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- muldiv_unit.f
muldiv_pkg.sv
muldiv_if.sv
muldiv_ctrl.sv
mul_pipe.sv
div_serial.sv
hilo_regs.sv
muldiv_unit.sv
muldiv_unit_chk.sv
tb_muldiv_unit.sv

//--- muldiv_unit.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_unit import muldiv_pkg::*; #(
    parameter int MUL_LATENCY = 2
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    issue,
    input  opcode_t opcode,
    input  func_t   func,
    input  word_t   rs_val,
    input  word_t   rt_val,
    output logic    busy,
    output word_t   hi,
    output word_t   lo,
    output dword_t  hilo
);

    logic    wr_hi;
    logic    wr_lo;
    wr_src_t wr_src;
    word_t   wr_data_rs;

    muldiv_if mdif ();

    muldiv_ctrl #(
        .MUL_LATENCY (MUL_LATENCY)
    ) u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .issue      (issue),
        .opcode     (opcode),
        .func       (func),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .busy       (busy),
        .ifc        (mdif.ctrl),
        .wr_hi      (wr_hi),
        .wr_lo      (wr_lo),
        .wr_src     (wr_src),
        .wr_data_rs (wr_data_rs)
    );

    mul_pipe #(
        .MUL_LATENCY (MUL_LATENCY)
    ) u_mul (
        .clk   (clk),
        .reset (reset),
        .ifc   (mdif.mul)
    );

    div_serial u_div (
        .clk   (clk),
        .reset (reset),
        .ifc   (mdif.div)
    );

    hilo_regs u_regs (
        .clk        (clk),
        .reset      (reset),
        .wr_hi      (wr_hi),
        .wr_lo      (wr_lo),
        .wr_src     (wr_src),
        .wr_data_rs (wr_data_rs),
        .ifc        (mdif.regs),
        .hi         (hi),
        .lo         (lo)
    );

    assign hilo = {hi, lo};

endmodule

`default_nettype wire

//--- muldiv_unit_chk.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_unit_chk (
    input  logic clk,
    input  logic reset,
    input  logic busy,
    input  logic mul_start,
    input  logic div_start,
    input  logic wr_hi,
    input  logic wr_lo
);

    // only one datapath runs at a time.
    a_start_excl: assert property (@(posedge clk) disable iff (reset)
        !(mul_start && div_start))
        else $error("mul_start and div_start are high together");

    a_idle_after_reset: assert property (@(posedge clk) reset |=> !busy)
        else $error("busy is high in the cycle after reset");

    // the result write and the end of busy share one edge.
    a_busy_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> $past(wr_hi && wr_lo))
        else $error("busy fell without a write to HI and LO");

    a_mul_pulse: assert property (@(posedge clk) disable iff (reset)
        mul_start |=> !mul_start)
        else $error("mul_start is wider than one cycle");

    a_div_pulse: assert property (@(posedge clk) disable iff (reset)
        div_start |=> !div_start)
        else $error("div_start is wider than one cycle");

endmodule

bind muldiv_unit muldiv_unit_chk u_chk (
    .clk       (clk),
    .reset     (reset),
    .busy      (busy),
    .mul_start (mdif.mul_start),
    .div_start (mdif.div_start),
    .wr_hi     (wr_hi),
    .wr_lo     (wr_lo)
);

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile and run the muldiv_unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_muldiv_unit -f muldiv_unit.f -o sim_muldiv

./obj_dir/sim_muldiv | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed" >&2
    exit 1
fi

//--- tb_muldiv_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_muldiv_unit import muldiv_pkg::*; ();

    localparam int MUL_LATENCY = 2;
    localparam int DIV_CYCLES  = 34; // accepting edge to the HI/LO write.
    localparam int MAX_WAIT    = 100;

    logic    clk;
    logic    reset;
    logic    issue;
    opcode_t opcode;
    func_t   func;
    word_t   rs_val;
    word_t   rt_val;
    logic    busy;
    word_t   hi;
    word_t   lo;
    dword_t  hilo;

    // the test in flight, handed from the stimulus to the compare process.
    string   cur_name;
    dword_t  cur_old;
    dword_t  cur_exp;
    int      cur_cycles;
    int      issued = 0;
    int      checked = 0;
    int      n_errors = 0;
    int      stim_errors = 0;
    dword_t  model_hilo;

    muldiv_unit #(
        .MUL_LATENCY (MUL_LATENCY)
    ) i_muldiv_unit (
        .clk    (clk),
        .reset  (reset),
        .issue  (issue),
        .opcode (opcode),
        .func   (func),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .busy   (busy),
        .hi     (hi),
        .lo     (lo),
        .hilo   (hilo)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // expected HI/LO pair after one accepted instruction.
    function automatic dword_t muldiv_ref(func_t fn, word_t rs, word_t rt, dword_t old);
        longint sa;
        longint sb;
        dword_t r;
        sa = {{32{rs[31]}}, rs};
        sb = {{32{rt[31]}}, rt};
        r  = old;
        case (fn)
            FUNC_MTHI:  r = {rs, old[31:0]};
            FUNC_MTLO:  r = {old[63:32], rs};
            FUNC_MULT:  r = sa * sb;
            FUNC_MULTU: r = {32'd0, rs} * {32'd0, rt};
            FUNC_DIV: begin
                if (rt == '0)
                    r = {rs, 32'hffff_ffff};
                else
                    r = {word_t'(sa % sb), word_t'(sa / sb)}; // truncates toward zero.
            end
            FUNC_DIVU: begin
                if (rt == '0)
                    r = {rs, 32'hffff_ffff};
                else
                    r = {rs % rt, rs / rt};
            end
            default:    r = old;
        endcase
        return r;
    endfunction

    function automatic int busy_cycles(opcode_t op, func_t fn);
        if (op != OP_SPECIAL)
            return 0;
        if (fn == FUNC_MULT || fn == FUNC_MULTU)
            return MUL_LATENCY + 1;
        if (fn == FUNC_DIV || fn == FUNC_DIVU)
            return DIV_CYCLES;
        return 0;
    endfunction

    function automatic word_t corner_value(int k);
        case (k)
            0:       return 32'h8000_0000;
            1:       return 32'hffff_ffff;
            default: return 32'h0000_0000;
        endcase
    endfunction

    function automatic word_t pick_operand();
        int k;
        k = $urandom % 8;
        if (k < 3)
            return corner_value(k);
        return $urandom;
    endfunction

    // poke raises a second issue in the cycle after acceptance, which must be ignored.
    task automatic run_op(input string name, input opcode_t op, input func_t fn,
                          input word_t rs, input word_t rt, input logic poke);
        int t;
        cur_name   = name;
        cur_old    = model_hilo;
        cur_exp    = (op == OP_SPECIAL) ? muldiv_ref(fn, rs, rt, model_hilo) : model_hilo;
        cur_cycles = busy_cycles(op, fn);
        @(posedge clk);
        issue  <= 1'b1;
        opcode <= op;
        func   <= fn;
        rs_val <= rs;
        rt_val <= rt;
        @(posedge clk);
        issued++;
        if (poke) begin
            func   <= FUNC_MTHI;
            rs_val <= ~rs;
            @(posedge clk);
        end
        issue <= 1'b0;
        t = 0;
        while (issued != checked && t < 2 * MAX_WAIT) begin
            @(posedge clk);
            t++;
        end
        if (issued != checked) begin
            $display("ERROR %s: the result was never checked", name);
            stim_errors++;
        end
        model_hilo = cur_exp;
    endtask

    initial begin : compare_results
        int   cycles;
        logic early;
        logic bad;
        forever begin
            @(negedge clk);
            if (issued != checked) begin
                cycles = 0;
                early  = 1'b0;
                bad    = 1'b0;
                while (busy && cycles < MAX_WAIT) begin
                    if (hilo !== cur_old)
                        early = 1'b1;
                    cycles++;
                    @(negedge clk);
                end
                if (busy) begin
                    $display("ERROR %s: busy did not fall within %0d cycles", cur_name, MAX_WAIT);
                    bad = 1'b1;
                end else if (cycles != cur_cycles) begin
                    $display("MISMATCH %s busy cycles: expected %0d actual %0d",
                             cur_name, cur_cycles, cycles);
                    bad = 1'b1;
                end
                if (early) begin
                    $display("ERROR %s: hilo changed while the unit was busy", cur_name);
                    bad = 1'b1;
                end
                if (hilo !== cur_exp) begin
                    $display("MISMATCH %s: expected %h actual %h", cur_name, cur_exp, hilo);
                    bad = 1'b1;
                end
                if (hi !== cur_exp[63:32]) begin
                    $display("MISMATCH %s hi: expected %h actual %h",
                             cur_name, cur_exp[63:32], hi);
                    bad = 1'b1;
                end
                if (lo !== cur_exp[31:0]) begin
                    $display("MISMATCH %s lo: expected %h actual %h",
                             cur_name, cur_exp[31:0], lo);
                    bad = 1'b1;
                end
                if (bad) begin
                    n_errors++;
                    $display("fail %s", cur_name);
                end else begin
                    $display("ok   %s hilo=%h", cur_name, hilo);
                end
                checked++;
            end
        end
    end

    initial begin : stimulus
        int      sel;
        opcode_t op;
        func_t   fn;
        void'($urandom(36777));
        reset      <= 1'b1;
        issue      <= 1'b0;
        opcode     <= '0;
        func       <= '0;
        rs_val     <= '0;
        rt_val     <= '0;
        model_hilo = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < 4; i++) begin
            run_op($sformatf("mthi_%0d", i), OP_SPECIAL, FUNC_MTHI, $urandom, $urandom, 1'b0);
            run_op($sformatf("mtlo_%0d", i), OP_SPECIAL, FUNC_MTLO, $urandom, $urandom, 1'b0);
        end
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                run_op($sformatf("mult_corner_%0d%0d", i, j), OP_SPECIAL, FUNC_MULT,
                       corner_value(i), corner_value(j), 1'b0);
                run_op($sformatf("multu_corner_%0d%0d", i, j), OP_SPECIAL, FUNC_MULTU,
                       corner_value(i), corner_value(j), 1'b0);
            end
        end
        for (int i = 0; i < 10; i++) begin
            run_op($sformatf("mult_%0d", i), OP_SPECIAL, FUNC_MULT, $urandom, $urandom, 1'b0);
            run_op($sformatf("multu_%0d", i), OP_SPECIAL, FUNC_MULTU, $urandom, $urandom, 1'b0);
            run_op($sformatf("div_%0d", i), OP_SPECIAL, FUNC_DIV, $urandom, $urandom, 1'b0);
            run_op($sformatf("divu_%0d", i), OP_SPECIAL, FUNC_DIVU, $urandom, $urandom, 1'b0);
        end
        run_op("div_min_by_m1", OP_SPECIAL, FUNC_DIV, 32'h8000_0000, 32'hffff_ffff, 1'b0);
        run_op("divu_min_by_m1", OP_SPECIAL, FUNC_DIVU, 32'h8000_0000, 32'hffff_ffff, 1'b0);
        run_op("div_neg_pos", OP_SPECIAL, FUNC_DIV, 32'hffff_fff9, 32'd2, 1'b0);
        run_op("div_pos_neg", OP_SPECIAL, FUNC_DIV, 32'd7, 32'hffff_fffe, 1'b0);
        run_op("div_neg_neg", OP_SPECIAL, FUNC_DIV, 32'hffff_fff9, 32'hffff_fffe, 1'b0);
        run_op("div_zero", OP_SPECIAL, FUNC_DIV, 32'hffff_fff9, 32'd0, 1'b0);
        run_op("div_zero_min", OP_SPECIAL, FUNC_DIV, 32'h8000_0000, 32'd0, 1'b0);
        run_op("divu_zero", OP_SPECIAL, FUNC_DIVU, $urandom, 32'd0, 1'b0);

        run_op("mult_issue_busy", OP_SPECIAL, FUNC_MULT, $urandom, $urandom, 1'b1);
        run_op("div_issue_busy", OP_SPECIAL, FUNC_DIV, $urandom, $urandom, 1'b1);
        run_op("bad_opcode", 6'h1c, FUNC_MULT, $urandom, $urandom, 1'b0);
        run_op("bad_func_mfhi", OP_SPECIAL, 6'h10, $urandom, $urandom, 1'b0);
        run_op("bad_func_add", OP_SPECIAL, 6'h20, $urandom, $urandom, 1'b0);

        for (int i = 0; i < 200; i++) begin
            sel = $urandom % 8;
            op  = OP_SPECIAL;
            case (sel)
                0:       fn = FUNC_MTHI;
                1:       fn = FUNC_MTLO;
                2:       fn = FUNC_MULT;
                3:       fn = FUNC_MULTU;
                4:       fn = FUNC_DIV;
                5:       fn = FUNC_DIVU;
                6:       fn = 6'h2a;
                default: begin
                    op = 6'h23;
                    fn = FUNC_DIV;
                end
            endcase
            run_op($sformatf("mix_%0d", i), op, fn, pick_operand(), pick_operand(), 1'b0);
        end

        repeat (2) @(posedge clk);
        $display("tests %0d, errors %0d", checked, n_errors + stim_errors);
        if (n_errors + stim_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
